//--- project.f
nvicIrqPkg.sv
nvicRegPkg.sv
nvicAxiSlave.sv
nvicIntState.sv
nvicIntEncoder.sv
Nvic.sv
nvicClkGen.sv
nvicChecker.sv
Nvic_sva.sv
tb_Nvic.sv

//--- Bender.yml
package:
  name: nvic

sources:
  - files:
      - nvicIrqPkg.sv
      - nvicRegPkg.sv
      - nvicAxiSlave.sv
      - nvicIntState.sv
      - nvicIntEncoder.sv
      - Nvic.sv
  - target: test
    files:
      - nvicClkGen.sv
      - nvicChecker.sv
      - Nvic_sva.sv
      - tb_Nvic.sv

//--- tb_Nvic.sv
// Nvic testbench
`timescale 1ns/10ps

module tb_Nvic;
	import nvicRegPkg::*;
	import nvicIrqPkg::*;

	localparam int          CLK_PERIOD       = 100;
	localparam int          NUM_TRANS        = 110; // Planned bus transfers and pulses
	localparam int          CYCLES_PER_TRANS = 24;  // Worst stall plus handshakes
	localparam int          TIMEOUT_NS       = (NUM_TRANS * CYCLES_PER_TRANS + 8) * CLK_PERIOD;
	localparam logic [31:0] SEED             = 32'hb957c5e7;

	logic               clk, rstN;
	logic               awvalid, wvalid, bready, arvalid, rready;
	logic [ADDR_W-1:0]  awaddr, araddr;
	logic [DATA_W-1:0]  wdata, rdata;
	logic [NUM_SRC-1:0] intSrc;
	logic               awready, wready, bvalid, arready, rvalid, intEn;
	logic [1:0]         bresp, rresp;
	logic [CODE_W-1:0]  intCode;
	logic [31:0]        rng;
	int                 testId, errCount, checkCount, totalErr;

	nvicClkGen u_clkGen (.o_clk(clk), .o_rstN(rstN));

	Nvic i_Nvic (
		.i_clk(clk), .i_rstN(rstN),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
		.o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
		.i_intSrc(intSrc), .o_intCode(intCode), .o_intEn(intEn)
	);

	nvicChecker u_checker (
		.i_clk(clk), .i_rstN(rstN), .i_awvalid(awvalid), .i_awready(awready),
		.i_awaddr(awaddr), .i_wvalid(wvalid), .i_wready(wready), .i_wdata(wdata),
		.i_arvalid(arvalid), .i_arready(arready), .i_araddr(araddr),
		.i_rvalid(rvalid), .i_rready(rready), .i_rdata(rdata), .i_intSrc(intSrc),
		.i_intCode(intCode), .i_intEn(intEn), .i_testId(testId),
		.o_errCount(errCount), .o_checkCount(checkCount)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// --------------------
	// Bus tasks, srcBits rides along with the write handshake
	task automatic axiWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [NUM_SRC-1:0] srcBits, input int stall);
		@(posedge clk);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= addr;
		wdata   <= data;
		intSrc  <= srcBits;
		bready  <= (stall == 0);
		do @(posedge clk); while (!awready);
		awvalid <= (stall != 0); // Stalled write is offered again at once
		wvalid  <= (stall != 0);
		intSrc  <= '0;
		repeat (stall) @(posedge clk); // B held meanwhile, repeat must wait
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		if (stall != 0) begin
			do @(posedge clk); while (!awready); // Repeat taken after B
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			do @(posedge clk); while (!bvalid);
		end
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [ADDR_W-1:0] addr, input int stall);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		rready  <= (stall == 0);
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		repeat (stall) @(posedge clk);
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		rready <= 1'b0;
	endtask

	task automatic pulseSrc(input logic [NUM_SRC-1:0] bits);
		@(posedge clk);
		intSrc <= bits;
		@(posedge clk);
		intSrc <= '0;
		repeat (3) @(posedge clk); // Let the code settle
	endtask

	initial begin : stimulus
		logic [NUM_SRC-1:0] named;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		intSrc  = '0;
		testId  = 0;
		rng     = SEED;
		@(posedge rstN);
		repeat (2) @(posedge clk);

		testId <= 1; // Sources active, mask zero
		axiRead(ADDR_ENABLE, 0);
		axiRead(ADDR_FLAG, 0);
		@(posedge clk);
		intSrc <= '1;
		repeat (6) @(posedge clk);
		intSrc <= '0;
		axiRead(ADDR_FLAG, 0);
		axiWrite(ADDR_FLAG, '0, '0, 0);

		testId <= 2; // Full random words, only bits 11:1 stick
		for (int i = 0; i < 4; i++) begin
			rng = lcgNext(rng);
			axiWrite(ADDR_ENABLE, rng, '0, 0);
			axiRead(ADDR_ENABLE, 0);
		end
		axiRead(4'h8, 0);
		axiRead(4'hC, 0);

		testId <= 3;
		for (int i = 0; i < 20; i++) begin
			rng = lcgNext(rng);
			axiWrite(ADDR_ENABLE, rng, '0, 0);
			rng = lcgNext(rng);
			pulseSrc(rng[NUM_SRC-1:0]);
			if (rng[20])
				axiWrite(ADDR_FLAG, '0, '0, 0); // Clear now and then
		end
		named = '0;
		named[SRC_EXL] = 1'b1;
		named[SRC_EXH] = 1'b1;
		named[SRC_OVF] = 1'b1;
		axiWrite(ADDR_FLAG, '0, '0, 0);
		axiWrite(ADDR_ENABLE, '1, '0, 0);
		pulseSrc(named); // OVF must win

		testId <= 4;
		axiWrite(ADDR_FLAG, '0, '0, 0);
		pulseSrc(NUM_SRC'(1) << 3);
		axiRead(ADDR_FLAG, 0);
		axiWrite(ADDR_FLAG, DATA_W'(1) << 6, NUM_SRC'(1) << 2, 0); // Write beats source 2
		axiRead(ADDR_FLAG, 0);

		testId <= 5;
		for (int i = 0; i < 8; i++) begin
			rng = lcgNext(rng);
			axiWrite({rng[3:2], 2'b00}, rng, '0, int'(rng[18:16]));
			rng = lcgNext(rng);
			axiRead({rng[3:2], 2'b00}, int'(rng[22:20]));
		end

		repeat (4) @(posedge clk);
		totalErr = errCount + i_Nvic.u_nvicSva.failCount;
		$display("Checks %0d, compare errors %0d, assertion failures %0d",
			checkCount, errCount, i_Nvic.u_nvicSva.failCount);
		if (totalErr == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- Nvic_sva.sv
// Nvic port assertions
`timescale 1ns/10ps

module Nvic_sva (
	input logic                          i_clk,
	input logic                          i_rstN,
	input logic                          i_awready,
	input logic                          i_wready,
	input logic                          i_bvalid,
	input logic                          i_bready,
	input logic [1:0]                    i_bresp,
	input logic                          i_arready,
	input logic                          i_rvalid,
	input logic                          i_rready,
	input logic [nvicRegPkg::DATA_W-1:0] i_rdata,
	input logic [1:0]                    i_rresp,
	input logic [nvicIrqPkg::CODE_W-1:0] i_intCode,
	input logic                          i_intEn
);
	import nvicRegPkg::*;

	int failCount; // Read by the testbench at the end

	// --------------------
	// B held, no new write while pending
	bHold: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_bvalid && !i_bready |=> i_bvalid && !i_awready)
		else begin
			$error("Write response dropped or new write taken before bready");
			failCount++;
		end

	// AW and W accepted together
	wrJoin: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_awready == i_wready)
		else begin
			$error("Write address ready and write data ready differ");
			failCount++;
		end

	// R held with stable data
	rHold: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_rvalid && !i_rready |=> i_rvalid && !i_arready && $stable(i_rdata))
		else begin
			$error("Read response changed or new read taken before rready");
			failCount++;
		end

	enMatch: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_intEn == (i_intCode != '0))
		else begin
			$error("Interrupt enable does not follow a nonzero code");
			failCount++;
		end

	respOkay: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_bresp == RESP_OKAY && i_rresp == RESP_OKAY)
		else begin
			$error("Bus response other than OKAY");
			failCount++;
		end

endmodule

bind Nvic Nvic_sva u_nvicSva (
	.i_clk(i_clk), .i_rstN(i_rstN), .i_awready(o_awready), .i_wready(o_wready),
	.i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp),
	.i_arready(o_arready), .i_rvalid(o_rvalid), .i_rready(i_rready),
	.i_rdata(o_rdata), .i_rresp(o_rresp),
	.i_intCode(o_intCode), .i_intEn(o_intEn)
);

//--- nvicChecker.sv
// Nvic response checker
`timescale 1ns/10ps

module nvicChecker (
	input  logic                           i_clk,
	input  logic                           i_rstN,
	input  logic                           i_awvalid,
	input  logic                           i_awready,
	input  logic [nvicRegPkg::ADDR_W-1:0]  i_awaddr,
	input  logic                           i_wvalid,
	input  logic                           i_wready,
	input  logic [nvicRegPkg::DATA_W-1:0]  i_wdata,
	input  logic                           i_arvalid,
	input  logic                           i_arready,
	input  logic [nvicRegPkg::ADDR_W-1:0]  i_araddr,
	input  logic                           i_rvalid,
	input  logic                           i_rready,
	input  logic [nvicRegPkg::DATA_W-1:0]  i_rdata,
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_intSrc,
	input  logic [nvicIrqPkg::CODE_W-1:0]  i_intCode,
	input  logic                           i_intEn,
	input  int                             i_testId,
	output int                             o_errCount,
	output int                             o_checkCount
);
	import nvicRegPkg::*;
	import nvicIrqPkg::*;

	logic [NUM_SRC-1:0] enableM, flagM; // Model registers
	logic [CODE_W-1:0]  codeM;          // Code the DUT holds now
	logic [DATA_W-1:0]  rdataM;         // Captured at AR handshake
	logic               wrHs;
	regWord_u           wordM;

	function automatic string testName(input int id);
		case (id)
			1:       return "reset";
			2:       return "readback";
			3:       return "priority";
			4:       return "sticky";
			5:       return "backpressure";
			default: return "idle";
		endcase
	endfunction

	// Expected code: one plus the highest pending index, 0 if none
	function automatic logic [CODE_W-1:0] refCode(input logic [NUM_SRC-1:0] pend);
		for (int k = NUM_SRC - 1; k >= 0; k--)
			if (pend[k])
				return CODE_W'(k + 1);
		return '0;
	endfunction

	// --------------------
	// Mid-cycle sampling, all signals settled
	always @(negedge i_clk) begin
		if (!i_rstN) begin
			enableM = '0;
			flagM   = '0;
			codeM   = '0;
		end else begin
			o_checkCount += 2;
			if (i_intCode !== codeM) begin
				o_errCount++;
				$display("** Error [%s] intCode expected %0d actual %0d",
					testName(i_testId), codeM, i_intCode);
			end
			if (i_intEn !== (codeM != '0)) begin
				o_errCount++;
				$display("** Error [%s] intEn expected %0b actual %0b",
					testName(i_testId), codeM != '0, i_intEn);
			end
			if (i_rvalid && i_rready) begin // R handshake
				o_checkCount++;
				if (i_rdata !== rdataM) begin
					o_errCount++;
					$display("** Error [%s] rdata expected %h actual %h",
						testName(i_testId), rdataM, i_rdata);
				end
			end
			if (i_arvalid && i_arready) begin // Register value before this edge
				wordM.raw = '0;
				if (i_araddr == ADDR_ENABLE)
					wordM.fields.irqBits = enableM;
				else if (i_araddr == ADDR_FLAG)
					wordM.fields.irqBits = flagM;
				rdataM = wordM.raw;
			end
			codeM = refCode(enableM & flagM); // Registered at the coming edge
			wrHs       = i_awvalid && i_awready && i_wvalid && i_wready;
			wordM.raw  = i_wdata;
			if (wrHs && i_awaddr == ADDR_FLAG)
				flagM = wordM.fields.irqBits; // Software write beats sources
			else if (|i_intSrc)
				flagM = flagM | i_intSrc;
			if (wrHs && i_awaddr == ADDR_ENABLE)
				enableM = wordM.fields.irqBits;
		end
	end

endmodule

//--- nvicClkGen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module nvicClkGen (
	output logic o_clk,
	output logic o_rstN
);
	localparam int HALF_PERIOD = 50; // 100 ns clock
	localparam int RST_CYCLES  = 8;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	initial begin
		o_rstN = 1'b0; // Held low from time zero
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rstN <= 1'b1;
	end

endmodule

//--- Nvic.sv
// Nvic top level
`timescale 1ns/10ps

module Nvic (
	input  logic                           i_clk,
	input  logic                           i_rstN,

	// AXI4-Lite slave
	input  logic                           i_awvalid,
	output logic                           o_awready,
	input  logic [nvicRegPkg::ADDR_W-1:0]  i_awaddr,
	input  logic                           i_wvalid,
	output logic                           o_wready,
	input  logic [nvicRegPkg::DATA_W-1:0]  i_wdata,
	output logic                           o_bvalid,
	input  logic                           i_bready,
	output logic [1:0]                     o_bresp,
	input  logic                           i_arvalid,
	output logic                           o_arready,
	input  logic [nvicRegPkg::ADDR_W-1:0]  i_araddr,
	output logic                           o_rvalid,
	input  logic                           i_rready,
	output logic [nvicRegPkg::DATA_W-1:0]  o_rdata,
	output logic [1:0]                     o_rresp,

	// Interrupt sources and core side
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_intSrc,
	output logic [nvicIrqPkg::CODE_W-1:0]  o_intCode,
	output logic                           o_intEn
);
	import nvicIrqPkg::*;

	logic               wrEnable, wrFlag; // Single-cycle write strobes
	logic [NUM_SRC-1:0] wrBits;
	logic [NUM_SRC-1:0] enableQ, flagQ;   // Read back by the slave
	logic [NUM_SRC-1:0] pending;

	// --------------------
	// Bus side
	nvicAxiSlave u_axiSlave (
		.i_clk(i_clk), .i_rstN(i_rstN),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.i_enableQ(enableQ), .i_flagQ(flagQ),
		.o_wrEnable(wrEnable), .o_wrFlag(wrFlag), .o_wrBits(wrBits)
	);

	// Mask and flags
	nvicIntState u_intState (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_intSrc(i_intSrc),
		.i_wrEnable(wrEnable), .i_wrFlag(wrFlag), .i_wrBits(wrBits),
		.o_enableQ(enableQ), .o_flagQ(flagQ), .o_pending(pending)
	);

	// --------------------
	// Core side
	nvicIntEncoder u_intEncoder (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_pending(pending),
		.o_intCode(o_intCode), .o_intEn(o_intEn)
	);

endmodule

//--- nvicIntEncoder.sv
// Nvic priority encoder
`timescale 1ns/10ps

module nvicIntEncoder (
	input  logic                           i_clk,
	input  logic                           i_rstN,
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_pending,
	output logic [nvicIrqPkg::CODE_W-1:0]  o_intCode,
	output logic                           o_intEn
);
	import nvicIrqPkg::*;

	logic [CODE_W-1:0] codeD; // Next code

	// --------------------
	// Highest index wins
	always_comb begin
		codeD = '0; // Nothing pending
		for (int k = 0; k < NUM_SRC; k++) begin
			if (i_pending[k])
				codeD = CODE_W'(k + 1); // Later hits override lower ones
		end
	end

	// Code and enable move together
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_intCode <= '0;
			o_intEn   <= 1'b0;
		end else begin
			o_intCode <= codeD;
			o_intEn   <= |codeD; // Code 0 has no interrupt
		end
	end

endmodule

//--- nvicIntState.sv
// Nvic enable and flag registers
`timescale 1ns/10ps

module nvicIntState (
	input  logic                           i_clk,
	input  logic                           i_rstN,

	// Hardware sources, level
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_intSrc,

	// Software writes from the bus slave
	input  logic                           i_wrEnable,
	input  logic                           i_wrFlag,
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_wrBits,

	// Register state
	output logic [nvicIrqPkg::NUM_SRC-1:0] o_enableQ,
	output logic [nvicIrqPkg::NUM_SRC-1:0] o_flagQ,
	output logic [nvicIrqPkg::NUM_SRC-1:0] o_pending
);

	logic anySrc; // Some source high this cycle

	assign anySrc = |i_intSrc;

	// --------------------
	// Enable mask
	// Only software changes it
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_enableQ <= '0;
		else if (i_wrEnable)
			o_enableQ <= i_wrBits;
	end

	// --------------------
	// Sticky flags
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_flagQ <= '0;
		else if (i_wrFlag)
			o_flagQ <= i_wrBits;            // Software write wins over sources
		else if (anySrc)
			o_flagQ <= o_flagQ | i_intSrc; // Merge new sets, keep old ones
	end

	// A flag only requests service when its mask bit is set
	assign o_pending = o_enableQ & o_flagQ;

endmodule

//--- nvicAxiSlave.sv
// Nvic AXI4-Lite slave
`timescale 1ns/10ps

module nvicAxiSlave (
	input  logic                          i_clk,
	input  logic                          i_rstN,

	// Write address / data
	input  logic                          i_awvalid,
	output logic                          o_awready,
	input  logic [nvicRegPkg::ADDR_W-1:0] i_awaddr,
	input  logic                          i_wvalid,
	output logic                          o_wready,
	input  logic [nvicRegPkg::DATA_W-1:0] i_wdata,

	// Write response
	output logic                          o_bvalid,
	input  logic                          i_bready,
	output logic [1:0]                    o_bresp,

	// Read address / data
	input  logic                          i_arvalid,
	output logic                          o_arready,
	input  logic [nvicRegPkg::ADDR_W-1:0] i_araddr,
	output logic                          o_rvalid,
	input  logic                          i_rready,
	output logic [nvicRegPkg::DATA_W-1:0] o_rdata,
	output logic [1:0]                    o_rresp,

	// Register side
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_enableQ,
	input  logic [nvicIrqPkg::NUM_SRC-1:0] i_flagQ,
	output logic                           o_wrEnable,
	output logic                           o_wrFlag,
	output logic [nvicIrqPkg::NUM_SRC-1:0] o_wrBits
);
	import nvicRegPkg::*;

	logic     wrAccept; // AW and W taken together
	logic     rdAccept; // AR taken
	regWord_u wrWord;   // Incoming bus word
	regWord_u rdWord;   // Selected register, not yet captured

	// --------------------
	// Write path
	assign wrAccept  = i_awvalid & i_wvalid & ~o_bvalid; // Blocked while B pending
	assign o_awready = wrAccept;
	assign o_wready  = wrAccept;

	assign wrWord.raw = i_wdata;
	assign o_wrBits   = wrWord.fields.irqBits; // Bit 0 and upper bits dropped

	// One strobe per mapped offset
	assign o_wrEnable = wrAccept & (i_awaddr == ADDR_ENABLE);
	assign o_wrFlag   = wrAccept & (i_awaddr == ADDR_FLAG);

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_bvalid <= 1'b0;
		else if (wrAccept)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0; // Response taken
	end

	assign o_bresp = RESP_OKAY;

	// --------------------
	// Read path
	assign o_arready = ~o_rvalid; // One read in flight
	assign rdAccept  = i_arvalid & ~o_rvalid;

	always_comb begin
		rdWord.raw = '0; // Unmapped reads zero
		case (i_araddr)
			ADDR_ENABLE: rdWord.fields.irqBits = i_enableQ;
			ADDR_FLAG:   rdWord.fields.irqBits = i_flagQ;
			default:     rdWord.raw = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			o_rvalid <= 1'b0;
		else if (rdAccept)
			o_rvalid <= 1'b1;
		else if (i_rready)
			o_rvalid <= 1'b0;
	end

	// Data held until R accepted
	always_ff @(posedge i_clk) begin
		if (rdAccept)
			o_rdata <= rdWord.raw;
	end

	assign o_rresp = RESP_OKAY;

endmodule

//--- nvicRegPkg.sv
// Nvic register map
package nvicRegPkg;

	// --------------------
	// Bus geometry
	localparam int ADDR_W = 4;  // Byte offset, four word slots
	localparam int DATA_W = 32; // AXI4-Lite data word

	// --------------------
	// Register offsets
	localparam logic [ADDR_W-1:0] ADDR_ENABLE = 4'h0; // Interrupt mask
	localparam logic [ADDR_W-1:0] ADDR_FLAG   = 4'h4; // Sticky flags
	// Offsets 0x8 and 0xC unmapped, read back zero

	localparam logic [1:0] RESP_OKAY = 2'b00; // Only response ever sent

	// Register data word
	// Seen either as the raw bus word or split into fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [DATA_W-nvicIrqPkg::NUM_SRC-2:0] reserved; // Bits 31:12, zero
			logic [nvicIrqPkg::NUM_SRC-1:0]        irqBits;  // Bits 11:1, per source
			logic                                   zero;     // Bit 0, unused
		} fields;
	} regWord_u;

endpackage

//--- nvicIrqPkg.sv
// Nvic interrupt sources
package nvicIrqPkg;

	// --------------------
	// Sizes
	localparam int NUM_SRC = 11; // Sources 0..10
	localparam int CODE_W  = 4;  // Code 0 = none, k+1 = source k

	// --------------------
	// Named sources
	// Higher index wins
	localparam int SRC_EXL = 0;  // Low external pin, lowest priority
	localparam int SRC_EXH = 9;  // High external pin
	localparam int SRC_OVF = 10; // Overflow, highest priority

	// Sources 1..8 are general purpose inputs

endpackage
